//--- design/branchUnit.sv
// status register updates only on statusWe; a branch sees flags from earlier instructions
`timescale 1ns/1ps

module branchUnit (
   input  logic                               Clock,
   input  logic                               nReset,
   input  logic [cpuCtrlPkg::FlagWidth-1:0]   flags,
   input  logic                               statusWe,
   input  cpuCtrlPkg::branchT                 cond,
   output logic                               carry,
   output logic                               takeBranch
);
   import cpuCtrlPkg::*;

   logic [FlagWidth-1:0] statusReg;
   logic                 signedLess;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (statusWe) begin
         statusReg <= flags;
      end
   end

   assign carry      = statusReg[FlagC];
   assign signedLess = statusReg[FlagN] ^ statusReg[FlagV]; // n != v

   always_comb begin
      case (cond)
         BR:      takeBranch = 1'b1;
         BE:      takeBranch = statusReg[FlagZ];
         BNE:     takeBranch = !statusReg[FlagZ];
         BLT:     takeBranch = signedLess;
         BGE:     takeBranch = !signedLess;
         default: takeBranch = 1'b0;           // reserved codes
      endcase
   end

endmodule

//--- design/busCycleGen.sv
// strobes assume memory answers within the fixed cycles; there is no wait input
`timescale 1ns/1ps

module busCycleGen (
   input  cpuCtrlPkg::majorStateT majorState,
   input  cpuCtrlPkg::subCycleT   subCycle,
   input  cpuCtrlPkg::memKindT    memKind,
   memStrobeIf.gen                bus
);
   import cpuCtrlPkg::*;

   logic isLoad;

   assign isLoad = (memKind == MemLoad);

   always_comb begin
      bus.ale   = 1'b0;
      bus.nMe   = 1'b1;
      bus.nOe   = 1'b1;
      bus.nWe   = 1'b1;
      bus.enb   = 1'b0;
      bus.memEn = 1'b0;
      if (majorState == Fetch) begin
         case (subCycle)
            Cycle0: bus.ale = 1'b1;            // pc address out
            Cycle1: begin
               bus.nMe   = 1'b0;
               bus.nOe   = 1'b0;
               bus.memEn = 1'b1;
            end
            Cycle2: begin
               bus.nMe   = 1'b0;
               bus.nOe   = 1'b0;
               bus.memEn = 1'b1;
               bus.enb   = 1'b1;               // instruction captured
            end
            default: begin                     // ir loads from the latched bus
               bus.nOe   = 1'b0;
               bus.memEn = 1'b1;
            end
         endcase
      end else if (memKind != MemNone) begin
         case (subCycle)
            Cycle1: bus.ale = 1'b1;
            Cycle2: begin
               bus.nMe   = 1'b0;
               bus.nOe   = !isLoad;
               bus.memEn = isLoad;
            end
            Cycle3: begin
               bus.nMe   = 1'b0;
               bus.nOe   = !isLoad;
               bus.nWe   = isLoad;             // write pulse on store
               bus.memEn = isLoad;
               bus.enb   = isLoad;
            end
            Cycle4: begin
               bus.nOe   = !isLoad;
               bus.memEn = isLoad;
            end
            default: bus.ale = 1'b0;           // Cycle0 is the address add
         endcase
      end
   end

endmodule

//--- design/controlUnit.sv
// OpcodeCondIn must hold from fetch Cycle3 to the last execute cycle; no interrupts or link register
`timescale 1ns/1ps

module controlUnit (
   input  logic                               Clock,
   input  logic                               nReset,
   input  logic [cpuCtrlPkg::OpcodeMsb:0]     OpcodeCondIn,
   input  logic [cpuCtrlPkg::FlagWidth-1:0]   Flags,
   output cpuCtrlPkg::aluFnT                  AluOp,
   output cpuCtrlPkg::op1SelT                 Op1Sel,
   output cpuCtrlPkg::op2SelT                 Op2Sel,
   output cpuCtrlPkg::immSelT                 ImmSel,
   output cpuCtrlPkg::wdSelT                  WdSel,
   output cpuCtrlPkg::rs1SelT                 Rs1Sel,
   output cpuCtrlPkg::pcSelT                  PcSel,
   output logic                               AluEn,
   output logic                               AluWe,
   output logic                               RegWe,
   output logic                               PcWe,
   output logic                               PcEn,
   output logic                               IrWe,
   output logic                               MemEn,
   output logic                               nWE,
   output logic                               nOE,
   output logic                               nME,
   output logic                               ENB,
   output logic                               ALE,
   output logic                               CFlag
);
   import cpuCtrlPkg::*;

   majorStateT majorState;
   subCycleT   subCycle;
   memKindT    memKind;
   branchT     branchCond;
   logic       statusWe;
   logic       takeBranch;

   dpCtrlIf    dpBus ();
   memStrobeIf memBus ();

   assign branchCond = branchT'(OpcodeCondIn[CondWidth-1:0]);

   phaseSequencer uSeq (
      .Clock      (Clock),
      .nReset     (nReset),
      .memKind    (memKind),
      .majorState (majorState),
      .subCycle   (subCycle)
   );

   instrDecoder uDec (
      .opcodeCond (OpcodeCondIn),
      .majorState (majorState),
      .subCycle   (subCycle),
      .takeBranch (takeBranch),
      .memKind    (memKind),
      .statusWe   (statusWe),
      .dp         (dpBus)
   );

   busCycleGen uBus (
      .majorState (majorState),
      .subCycle   (subCycle),
      .memKind    (memKind),
      .bus        (memBus)
   );

   branchUnit uBranch (
      .Clock      (Clock),
      .nReset     (nReset),
      .flags      (Flags),
      .statusWe   (statusWe),
      .cond       (branchCond),
      .carry      (CFlag),
      .takeBranch (takeBranch)
   );

   assign AluOp  = dpBus.aluOp;
   assign Op1Sel = dpBus.op1Sel;
   assign Op2Sel = dpBus.op2Sel;
   assign ImmSel = dpBus.immSel;
   assign WdSel  = dpBus.wdSel;
   assign Rs1Sel = dpBus.rs1Sel;
   assign PcSel  = dpBus.pcSel;
   assign AluEn  = dpBus.aluEn;
   assign AluWe  = dpBus.aluWe;
   assign RegWe  = dpBus.regWe;
   assign PcWe   = dpBus.pcWe;
   assign PcEn   = dpBus.pcEn;
   assign IrWe   = dpBus.irWe;

   assign ALE    = memBus.ale;
   assign nME    = memBus.nMe;
   assign nOE    = memBus.nOe;
   assign nWE    = memBus.nWe;
   assign ENB    = memBus.enb;
   assign MemEn  = memBus.memEn;

endmodule

//--- design/cpuCtrlPkg.sv
// encodings are specific to this core; the assembler must use the same opcode values
package cpuCtrlPkg;

   localparam int OpcodeMsb = 7;               // instruction field is [7:0]
   localparam int OpcodeLsb = 3;               // opcode in [7:3]
   localparam int CondWidth = 3;               // branch condition in [2:0]

   localparam int FlagWidth = 4;
   localparam int FlagZ     = 0;
   localparam int FlagN     = 1;
   localparam int FlagV     = 2;
   localparam int FlagC     = 3;

   typedef enum logic [4:0] {
      ADD    = 5'h00,
      ADDI   = 5'h01,
      ADDIB  = 5'h02,
      ADC    = 5'h03,
      ADCI   = 5'h04,
      SUB    = 5'h05,
      SUBI   = 5'h06,
      SUBIB  = 5'h07,
      SUC    = 5'h08,
      SUCI   = 5'h09,
      NEG    = 5'h0a,
      CMP    = 5'h0b,
      CMPI   = 5'h0c,
      AND    = 5'h0d,
      OR     = 5'h0e,
      XOR    = 5'h0f,
      NOT    = 5'h10,
      NAND   = 5'h11,
      NOR    = 5'h12,
      LSL    = 5'h13,
      LSR    = 5'h14,
      ASR    = 5'h15,
      LUI    = 5'h16,
      LLI    = 5'h17,
      LDW    = 5'h18,
      STW    = 5'h19,
      BRANCH = 5'h1f
   } opcodeT;

   typedef enum logic [2:0] {
      BR  = 3'd0,
      BE  = 3'd1,
      BNE = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4
   } branchT;                                  // codes 5..7 never taken

   typedef enum logic [4:0] {
      FnA, FnADD, FnADC, FnSUB, FnSUC, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR, FnLUI, FnLLI
   } aluFnT;

   typedef enum logic {Op1Rd1, Op1Pc}     op1SelT;
   typedef enum logic {Op2Imm, Op2Rd2}    op2SelT;
   typedef enum logic {ImmShort, ImmLong} immSelT;
   typedef enum logic {WdAlu, WdSys}      wdSelT;
   typedef enum logic {Rs1Ra, Rs1Rd}      rs1SelT;
   typedef enum logic {Pc1, PcAluOut}     pcSelT;

   typedef enum logic {Fetch, Execute} majorStateT;

   typedef enum logic [2:0] {
      Cycle0, Cycle1, Cycle2, Cycle3, Cycle4
   } subCycleT;

   typedef enum logic [1:0] {MemNone, MemLoad, MemStore} memKindT;

endpackage

//--- design/dpCtrlIf.sv
// purely combinational bundle, valid only while the instruction field is held stable
`timescale 1ns/1ps

interface dpCtrlIf;
   import cpuCtrlPkg::*;

   aluFnT  aluOp;
   op1SelT op1Sel;
   op2SelT op2Sel;
   immSelT immSel;
   wdSelT  wdSel;
   rs1SelT rs1Sel;
   pcSelT  pcSel;
   logic   aluEn;                              // alu result onto system bus
   logic   aluWe;                              // alu output register load
   logic   regWe;
   logic   pcWe;
   logic   pcEn;                               // pc onto system bus
   logic   irWe;

   modport dec (
      output aluOp, op1Sel, op2Sel, immSel, wdSel, rs1Sel, pcSel,
      output aluEn, aluWe, regWe, pcWe, pcEn, irWe
   );

   modport top (
      input aluOp, op1Sel, op2Sel, immSel, wdSel, rs1Sel, pcSel,
      input aluEn, aluWe, regWe, pcWe, pcEn, irWe
   );
endinterface

//--- design/instrDecoder.sv
// opcode bits are decoded from fetch Cycle3 onward; earlier fetch cycles ignore them
`timescale 1ns/1ps

module instrDecoder (
   input  logic [cpuCtrlPkg::OpcodeMsb:0] opcodeCond,
   input  cpuCtrlPkg::majorStateT         majorState,
   input  cpuCtrlPkg::subCycleT           subCycle,
   input  logic                           takeBranch,
   output cpuCtrlPkg::memKindT            memKind,
   output logic                           statusWe,
   dpCtrlIf.dec                           dp
);
   import cpuCtrlPkg::*;

   opcodeT  opcode;
   memKindT opKind;
   aluFnT   aluFn;

   assign opcode    = opcodeT'(opcodeCond[OpcodeMsb:OpcodeLsb]);
   assign opKind    = (opcode == LDW) ? MemLoad : (opcode == STW) ? MemStore : MemNone;

   always_comb begin
      case (opcode)
         ADD, ADDI, ADDIB:            aluFn = FnADD;
         ADC, ADCI:                   aluFn = FnADC;
         SUB, SUBI, SUBIB, CMP, CMPI: aluFn = FnSUB;
         SUC, SUCI:                   aluFn = FnSUC;
         NEG:                         aluFn = FnNEG;
         AND:                         aluFn = FnAND;
         OR:                          aluFn = FnOR;
         XOR:                         aluFn = FnXOR;
         NOT:                         aluFn = FnNOT;
         NAND:                        aluFn = FnNAND;
         NOR:                         aluFn = FnNOR;
         LSL:                         aluFn = FnLSL;
         LSR:                         aluFn = FnLSR;
         ASR:                         aluFn = FnASR;
         LUI:                         aluFn = FnLUI;
         LLI:                         aluFn = FnLLI;
         default:                     aluFn = FnADD; // address and branch target adds
      endcase
   end

   always_comb begin
      dp.aluOp  = FnA;
      dp.op1Sel = Op1Rd1;
      dp.op2Sel = Op2Imm;
      dp.immSel = ImmLong;
      dp.wdSel  = WdAlu;
      dp.rs1Sel = Rs1Ra;
      dp.pcSel  = Pc1;
      dp.aluEn  = 1'b0;
      dp.aluWe  = 1'b0;
      dp.regWe  = 1'b0;
      dp.pcWe   = 1'b0;
      dp.pcEn   = 1'b0;
      dp.irWe   = 1'b0;
      statusWe  = 1'b0;
      memKind   = MemNone;
      if (majorState == Fetch) begin
         dp.pcEn = (subCycle == Cycle0);       // pc drives the fetch address
         if (subCycle == Cycle3) begin
            dp.irWe = 1'b1;
            memKind = opKind;
         end
      end else begin
         memKind = opKind;
         case (subCycle)
            Cycle0: begin
               case (opcode)
                  ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, NEG,
                  CMP, CMPI, AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR: begin
                     dp.aluOp = aluFn;
                     dp.pcEn  = 1'b1;
                     dp.pcWe  = 1'b1;
                     dp.regWe = (opcode != CMP) && (opcode != CMPI); // compares keep rd
                     statusWe = 1'b1;
                     case (opcode)
                        ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR:
                           dp.op2Sel = Op2Rd2;
                        ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR:
                           dp.immSel = ImmShort;
                        ADDIB, SUBIB:
                           dp.rs1Sel = Rs1Rd;  // byte immediate against rd
                        default:
                           dp.op2Sel = Op2Imm; // NEG and NOT use op1 only
                     endcase
                  end
                  LUI, LLI: begin
                     dp.aluOp  = aluFn;
                     dp.rs1Sel = Rs1Rd;
                     dp.aluEn  = 1'b1;
                     dp.regWe  = 1'b1;
                     dp.pcWe   = 1'b1;
                  end
                  LDW, STW: begin              // effective address add
                     dp.aluOp  = aluFn;
                     dp.immSel = ImmShort;
                     dp.aluEn  = 1'b1;
                     dp.aluWe  = 1'b1;
                  end
                  BRANCH: begin
                     dp.aluOp  = aluFn;
                     dp.op1Sel = Op1Pc;        // pc plus long offset
                     dp.aluEn  = 1'b1;
                     dp.pcWe   = 1'b1;
                     dp.pcSel  = takeBranch ? PcAluOut : Pc1;
                  end
                  default: dp.pcWe = 1'b1;     // undefined opcode skips ahead
               endcase
            end
            Cycle1: begin                      // hold address during ale
               dp.aluOp  = FnADD;
               dp.immSel = ImmShort;
               dp.aluEn  = 1'b1;
            end
            Cycle2: begin                      // rd through alu for store data
               dp.rs1Sel = Rs1Rd;
               dp.aluEn  = 1'b1;
               dp.aluWe  = 1'b1;
            end
            Cycle3: dp.aluEn = (opKind == MemStore);
            default: begin                     // Cycle4 completes the access
               dp.pcWe  = 1'b1;
               dp.aluEn = (opKind == MemStore);
               if (opKind == MemLoad) begin
                  dp.wdSel = WdSys;
                  dp.regWe = 1'b1;
               end
            end
         endcase
      end
   end

endmodule

//--- design/memStrobeIf.sv
// fixed-timing memory strobes with no wait states; strobes other than ale and enb are active low
`timescale 1ns/1ps

interface memStrobeIf;
   logic ale;                                  // address phase
   logic nMe;                                  // memory select
   logic nOe;                                  // output enable
   logic nWe;                                  // write strobe
   logic enb;                                  // read data capture
   logic memEn;                                // pad direction, high while reading

   modport gen (
      output ale, nMe, nOe, nWe, enb, memEn
   );

   modport top (
      input ale, nMe, nOe, nWe, enb, memEn
   );
endinterface

//--- design/phaseSequencer.sv
// memKind is sampled only in execute Cycle0; every other step is unconditional
`timescale 1ns/1ps

module phaseSequencer (
   input  logic                   Clock,
   input  logic                   nReset,
   input  cpuCtrlPkg::memKindT    memKind,
   output cpuCtrlPkg::majorStateT majorState,
   output cpuCtrlPkg::subCycleT   subCycle
);
   import cpuCtrlPkg::*;

   majorStateT majorNext;
   subCycleT   subNext;

   always_comb begin
      majorNext = majorState;
      subNext   = subCycle;
      if (majorState == Fetch) begin
         case (subCycle)
            Cycle0: subNext = Cycle1;
            Cycle1: subNext = Cycle2;
            Cycle2: subNext = Cycle3;
            default: begin                     // Cycle3 ends the fetch
               majorNext = Execute;
               subNext   = Cycle0;
            end
         endcase
      end else begin
         case (subCycle)
            Cycle0: begin
               if (memKind == MemNone) begin   // single-cycle op done
                  majorNext = Fetch;
                  subNext   = Cycle0;
               end else begin
                  subNext = Cycle1;
               end
            end
            Cycle1: subNext = Cycle2;
            Cycle2: subNext = Cycle3;
            Cycle3: subNext = Cycle4;
            default: begin                     // Cycle4 or illegal code
               majorNext = Fetch;
               subNext   = Cycle0;
            end
         endcase
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         majorState <= Fetch;
         subCycle   <= Cycle0;
      end else begin
         majorState <= majorNext;
         subCycle   <= subNext;
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module controlUnitTb -f tb.f

# keep running past $error so the testbench reports the failure itself
./obj_dir/VcontrolUnitTb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
   echo "run.sh: simulation passed"
else
   echo "run.sh: simulation failed, see sim.log"
   exit 1
fi

//--- tb.f
design/cpuCtrlPkg.sv
design/dpCtrlIf.sv
design/memStrobeIf.sv
design/phaseSequencer.sv
design/instrDecoder.sv
design/busCycleGen.sv
design/branchUnit.sv
design/controlUnit.sv
verif/controlUnit_assertions.sv
verif/controlUnitTb.sv

//--- verif/controlUnitTb.sv
// checking is done by the bound assertions; a new instruction is applied only while IrWe is high
`timescale 1ns/1ps

module controlUnitTb;
   import cpuCtrlPkg::*;

   localparam int ClockPeriod = 20;

   logic                 Clock;
   logic                 nReset;
   logic [OpcodeMsb:0]   OpcodeCondIn;
   logic [FlagWidth-1:0] Flags;
   aluFnT                AluOp;
   op1SelT               Op1Sel;
   op2SelT               Op2Sel;
   immSelT               ImmSel;
   wdSelT                WdSel;
   rs1SelT               Rs1Sel;
   pcSelT                PcSel;
   logic                 AluEn, AluWe, RegWe, PcWe, PcEn, IrWe, MemEn;
   logic                 nWE, nOE, nME, ENB, ALE, CFlag;

   logic [OpcodeMsb:0]   instrList[$];
   integer               seed;

   controlUnit DUT (.*);

   initial begin
      Clock = 1'b0;
      forever #(ClockPeriod / 2) Clock = ~Clock;
   end

   task automatic buildInstrList();
      opcodeT op;
      int     c;
      op = ADD;
      repeat (24) begin                        // ADD through LLI
         instrList.push_back({op, 3'b000});
         op = op.next();
      end
      instrList.push_back({LDW, 3'b000});
      instrList.push_back({STW, 3'b000});
      instrList.push_back({LDW, 3'b000});
      instrList.push_back({STW, 3'b000});
      repeat (2) begin
         for (c = 0; c < 8; c++) begin         // codes 5..7 are reserved
            instrList.push_back({SUB, 3'b000}); // captures fresh flags
            instrList.push_back({LUI, 3'b000}); // must not touch the status
            instrList.push_back({BRANCH, 3'(c)});
         end
      end
   endtask

   // returns 1 ns after the edge that starts fetch Cycle3
   task automatic waitForFetchEnd();
      do begin
         @(posedge Clock);
         #1;
      end while (!IrWe);
   endtask

   initial begin : stimulus
      nReset       = 1'b0;
      OpcodeCondIn = {ADD, 3'b000};
      Flags        = '0;
      seed         = 32'h7d02_b0d7;
      buildInstrList();
      repeat (2) @(posedge Clock);
      #1;
      nReset = 1'b1;
      foreach (instrList[i]) begin
         waitForFetchEnd();
         OpcodeCondIn = instrList[i];
      end
      waitForFetchEnd();                       // last instruction has retired
      repeat (2) @(posedge Clock);
      #1;
      if (DUT.checks.failCount == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         $display("TB FAILED");
         $fatal(1, "assertion failures were recorded");
      end
   end

   initial begin : flagDriver
      forever begin
         @(posedge Clock);
         #1;
         Flags = 4'($random(seed));
      end
   end

   initial begin : failureMonitor
      wait (DUT.checks.failCount != 0);
      $display("TB FAILED");
      $fatal(1, "an assertion failed, stopping at the first error");
   end

   initial begin : watchdog
      #1;                                      // list is built at time zero
      #(ClockPeriod * 9 * 2 * instrList.size());
      $display("TB FAILED");
      $fatal(1, "watchdog expired before the instruction list finished");
   end

endmodule

//--- verif/controlUnit_assertions.sv
// observes controlUnit ports only; execIdx assumes OpcodeCondIn is held from IrWe to the last execute cycle
`timescale 1ns/1ps

module controlUnitAssertions (
   input logic                               Clock,
   input logic                               nReset,
   input logic [cpuCtrlPkg::OpcodeMsb:0]     OpcodeCondIn,
   input logic [cpuCtrlPkg::FlagWidth-1:0]   Flags,
   input cpuCtrlPkg::aluFnT                  AluOp,
   input cpuCtrlPkg::op1SelT                 Op1Sel,
   input cpuCtrlPkg::op2SelT                 Op2Sel,
   input cpuCtrlPkg::immSelT                 ImmSel,
   input cpuCtrlPkg::wdSelT                  WdSel,
   input cpuCtrlPkg::rs1SelT                 Rs1Sel,
   input cpuCtrlPkg::pcSelT                  PcSel,
   input logic                               AluEn,
   input logic                               AluWe,
   input logic                               RegWe,
   input logic                               PcWe,
   input logic                               PcEn,
   input logic                               IrWe,
   input logic                               MemEn,
   input logic                               nWE,
   input logic                               nOE,
   input logic                               nME,
   input logic                               ENB,
   input logic                               ALE,
   input logic                               CFlag
);
   import cpuCtrlPkg::*;

   int                   failCount = 0;        // read by the testbench
   logic [3:0]           execIdx;              // 1 = execute Cycle0, saturates at 15
   logic [FlagWidth-1:0] savedFlags;
   opcodeT               op;
   logic                 isAluOp;
   logic                 isMem;
   logic                 isLoad;
   logic                 regForm;              // register-register ALU forms
   logic                 rdBase;               // forms that take rd as first operand

   assign op      = opcodeT'(OpcodeCondIn[OpcodeMsb:OpcodeLsb]);
   assign isAluOp = op inside {[ADD:LLI]};
   assign isMem   = (op == LDW) || (op == STW);
   assign isLoad  = (op == LDW);
   assign regForm = op inside {ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR};
   assign rdBase  = op inside {ADDIB, SUBIB, LUI, LLI};

   function automatic aluFnT expectedAluFn(opcodeT code);
      case (code)
         ADD, ADDI, ADDIB:            return FnADD;
         ADC, ADCI:                   return FnADC;
         SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
         SUC, SUCI:                   return FnSUC;
         NEG:                         return FnNEG;
         AND:                         return FnAND;
         OR:                          return FnOR;
         XOR:                         return FnXOR;
         NOT:                         return FnNOT;
         NAND:                        return FnNAND;
         NOR:                         return FnNOR;
         LSL:                         return FnLSL;
         LSR:                         return FnLSR;
         ASR:                         return FnASR;
         LUI:                         return FnLUI;
         LLI:                         return FnLLI;
         default:                     return FnA;
      endcase
   endfunction

   function automatic logic branchExpected(logic [CondWidth-1:0] cond, logic [FlagWidth-1:0] f);
      case (branchT'(cond))
         BR:      return 1'b1;
         BE:      return f[FlagZ];
         BNE:     return !f[FlagZ];
         BLT:     return f[FlagN] != f[FlagV];
         BGE:     return f[FlagN] == f[FlagV];
         default: return 1'b0;                 // reserved codes
      endcase
   endfunction

   task automatic recordFailure(input string what);
      failCount = failCount + 1;
      $error("FAILED %0t ns: %s", $time, what);
   endtask

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         execIdx    <= 4'd0;
         savedFlags <= '0;
      end else begin
         if (IrWe) begin
            execIdx <= 4'd1;
         end else if (execIdx != 4'd0 && execIdx != 4'd15) begin
            execIdx <= execIdx + 4'd1;
         end
         if (execIdx == 4'd1 && op inside {[ADD:ASR]}) begin
            savedFlags <= Flags;                // flag-writing ops only
         end
      end
   end

   resetState: assert property (@(posedge Clock)
      (!nReset || $rose(nReset)) |-> ALE && !RegWe && !PcWe && !IrWe)
      else recordFailure("outputs wrong during or right after reset");

   fetchStart: assert property (@(posedge Clock) disable iff (!nReset)
      (ALE && PcEn) |=> !nME && !IrWe)
      else recordFailure("fetch address phase not followed by nME low");

   fetchLength: assert property (@(posedge Clock) disable iff (!nReset)
      IrWe |-> $past(ALE && PcEn, 3) && !$past(nME, 1) && !$past(nME, 2))
      else recordFailure("IrWe not 4 cycles after fetch ALE");

   aluExec: assert property (@(posedge Clock) disable iff (!nReset)
      (execIdx == 4'd1 && isAluOp) |->
         PcWe && (RegWe == !(op == CMP || op == CMPI)) && AluOp == expectedAluFn(op))
      else recordFailure("ALU op has wrong PcWe, RegWe or AluOp");

   aluOperands: assert property (@(posedge Clock) disable iff (!nReset)
      (execIdx == 4'd1 && isAluOp) |->
         ((Op2Sel == Op2Rd2) == regForm) && ((Rs1Sel == Rs1Rd) == rdBase))
      else recordFailure("ALU op has wrong Op2Sel or Rs1Sel");

   memAddrAdd: assert property (@(posedge Clock) disable iff (!nReset)
      (execIdx == 4'd1 && isMem) |-> AluEn && AluWe && ImmSel == ImmShort && AluOp == FnADD)
      else recordFailure("load/store address add has wrong ALU controls");

   memAddress: assert property (@(posedge Clock) disable iff (!nReset)
      (execIdx == 4'd2 && isMem) |-> ALE && nME && !PcWe && !RegWe)
      else recordFailure("load/store address phase missing");

   memData: assert property (@(posedge Clock) disable iff (!nReset)
      (execIdx inside {4'd3, 4'd4} && isMem) |-> !nME && (ENB == (isLoad && execIdx == 4'd4)))
      else recordFailure("load/store data cycles wrong");

   memDone: assert property (@(posedge Clock) disable iff (!nReset)
      (execIdx == 4'd5 && isMem && !IrWe) |->
         PcWe && (RegWe == isLoad) && (!isLoad || WdSel == WdSys))
      else recordFailure("load/store completion cycle wrong");

   readDirection: assert property (@(posedge Clock) disable iff (!nReset)
      (execIdx inside {[4'd1:4'd5]} && isMem && !IrWe) |-> MemEn == (isLoad && execIdx >= 4'd3))
      else recordFailure("MemEn wrong during load/store");

   writeStrobe: assert property (@(posedge Clock) disable iff (!nReset)
      nWE == !(op == STW && execIdx == 4'd4))
      else recordFailure("nWE pulse not in the second store data cycle");

   storeQuiet: assert property (@(posedge Clock) disable iff (!nReset)
      (execIdx inside {[4'd1:4'd5]} && op == STW && !IrWe) |-> nOE && !RegWe && !ENB)
      else recordFailure("store drove nOE, RegWe or ENB");

   branchPick: assert property (@(posedge Clock) disable iff (!nReset)
      (execIdx == 4'd1 && op == BRANCH) |->
         PcWe && Op1Sel == Op1Pc && AluOp == FnADD &&
         ((PcSel == PcAluOut) == branchExpected(OpcodeCondIn[CondWidth-1:0], savedFlags)))
      else recordFailure("branch decision does not match saved flags");

   carryOut: assert property (@(posedge Clock) disable iff (!nReset)
      CFlag == savedFlags[FlagC])
      else recordFailure("CFlag differs from last captured carry");

endmodule

bind controlUnit controlUnitAssertions checks (.*);
